//--- logic/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Width of each signed saturating counter.
`define BP_COUNTER_WIDTH 2

// Value loaded into every counter and count register at reset.
`define BP_COUNTER_INIT 0

// Table index width, 256 entries.
`define BP_INDEX_WIDTH 8

// History bits that take part in the hash.
`define BP_HR_WIDTH 6

// Two spare bits allow repair of the id and ex stage outcomes.
`define BP_HR_DEPTH (`BP_HR_WIDTH + 2)

`endif

//--- logic/pipeline_pkg.sv
package pipeline_pkg;

  localparam int PC_WIDTH = 32;

  // Program counter as seen by every stage.
  typedef logic [PC_WIDTH-1:0] pc_t;

  // High when the stage registers may take new values.
  typedef logic stage_en_t;

  // Low pc bits below the instruction word are not used for indexing.
  localparam int PC_WORD_LSB = 2;

endpackage

//--- logic/predictor_pkg.sv
`include "bp_defines.svh"

package predictor_pkg;

  // Two's complement counter. Negative values lean one way, the rest the other.
  typedef logic signed [`BP_COUNTER_WIDTH-1:0] counter_t;

  // Pattern table index.
  typedef logic [`BP_INDEX_WIDTH-1:0] index_t;

  // Global history, newest outcome in bit 0.
  typedef logic [`BP_HR_DEPTH-1:0] history_t;

  // Reset value in counter form.
  localparam counter_t COUNTER_INIT = counter_t'(`BP_COUNTER_INIT);

  // Positions of the hash slices taken from the history.
  localparam int HR_FETCH_LSB = 0;
  localparam int HR_ID_LSB    = 1;
  localparam int HR_EX_LSB    = 2;

endpackage

//--- logic/index_hash.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module index_hash #(
  parameter int HR_WIDTH    = `BP_HR_WIDTH,
  parameter int INDEX_WIDTH = `BP_INDEX_WIDTH
) (
  input  pipeline_pkg::pc_t       pc,
  input  logic [HR_WIDTH-1:0]     hr,
  output logic [INDEX_WIDTH-1:0]  index
);

  import pipeline_pkg::*;

  generate
    if (HR_WIDTH < INDEX_WIDTH) begin : g_concat
      localparam int PC_TOP = INDEX_WIDTH - HR_WIDTH + PC_WORD_LSB - 1;

      // Pc bits fill the index above the history.
      assign index = {pc[PC_TOP:PC_WORD_LSB], hr};
    end else begin : g_fold
      logic [HR_WIDTH-1:0] mixed;

      assign mixed = hr ^ pc[HR_WIDTH+PC_WORD_LSB-1:PC_WORD_LSB];

      // Wider history is folded onto the index in INDEX_WIDTH chunks.
      always_comb begin
        index = '0;
        for (int k = 0; k < HR_WIDTH; k++) begin
          index[k % INDEX_WIDTH] = index[k % INDEX_WIDTH] ^ mixed[k];
        end
      end
    end
  endgenerate

endmodule

//--- logic/saturating_counter_step.sv
`timescale 1ns/1ps

module saturating_counter_step (
  input  predictor_pkg::counter_t count,
  input  logic                    decrement,
  output predictor_pkg::counter_t next_count
);

  import predictor_pkg::*;

  localparam int W = $bits(counter_t);
  localparam counter_t MAX_COUNT = {1'b0, {(W-1){1'b1}}};
  localparam counter_t MIN_COUNT = {1'b1, {(W-1){1'b0}}};
  localparam counter_t ONE       = counter_t'(1);

  always_comb begin
    if (decrement) begin
      next_count = (count == MIN_COUNT) ? count : count - ONE; // Hold at the negative end.
    end else begin
      next_count = (count == MAX_COUNT) ? count : count + ONE; // Hold at the positive end.
    end
  end

endmodule

//--- logic/pattern_history_table.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module pattern_history_table (
  input  logic                    clk,
  input  logic                    rst_n,
  input  predictor_pkg::index_t   rd_index,
  input  logic                    wr_en1,
  input  predictor_pkg::index_t   wr_index1,
  input  predictor_pkg::counter_t wr_count1,
  input  logic                    wr_en2,
  input  predictor_pkg::index_t   wr_index2,
  input  predictor_pkg::counter_t wr_count2,
  output predictor_pkg::counter_t rd_count
);

  import predictor_pkg::*;

  localparam int ENTRIES = 1 << `BP_INDEX_WIDTH;

  counter_t entries_q [ENTRIES];

  // The whole table is cleared so every branch starts from the same bias.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        entries_q[i] <= COUNTER_INIT;
      end
    end else begin
      if (wr_en1) begin
        entries_q[wr_index1] <= wr_count1;
      end
      if (wr_en2) begin
        entries_q[wr_index2] <= wr_count2; // Later write wins on the same entry.
      end
    end
  end

  assign rd_count = entries_q[rd_index];

endmodule

//--- logic/pc_stage_pipe.sv
`timescale 1ns/1ps

module pc_stage_pipe (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall_ex,
  input  pipeline_pkg::pc_t pc,
  output pipeline_pkg::pc_t pc_id,
  output pipeline_pkg::pc_t pc_ex
);

  import pipeline_pkg::*;

  stage_en_t advance;

  assign advance = !stall_ex;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_id <= '0;
      pc_ex <= '0;
    end else if (advance) begin
      pc_id <= pc;
      pc_ex <= pc_id; // Stays aligned with count_ex in the predictor.
    end
  end

endmodule

//--- logic/history_predictor.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module history_predictor (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_ex,
  input  logic                    corrected_en,
  input  logic                    corrected_result,
  input  logic                    rollback_en_id,
  input  logic                    rollback_en_ex,
  input  pipeline_pkg::pc_t       pc,
  input  pipeline_pkg::pc_t       pc_id,
  input  pipeline_pkg::pc_t       pc_ex,
  output predictor_pkg::counter_t count,
  output predictor_pkg::counter_t count_id,
  output predictor_pkg::counter_t count_ex
);

  import predictor_pkg::*;
  import pipeline_pkg::*;

  localparam int HR_WIDTH = `BP_HR_WIDTH;
  localparam int HR_DEPTH = `BP_HR_DEPTH;

  history_t  history_q;
  history_t  history_shifted;
  stage_en_t advance;
  index_t    index_fetch;
  index_t    index_id;
  index_t    index_ex_rid;
  index_t    index_ex_nrid;
  index_t    wr_index2;
  counter_t  step_corrected;
  counter_t  step_rollback;
  counter_t  wr_count2;
  logic      index_conflict;
  logic      wr_en1;
  logic      wr_en2;

  assign advance = !stall_ex;

  // An id rollback also drops the youngest bit, so ex sees one place lower.
  assign history_shifted = history_q >> rollback_en_id;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_id  <= COUNTER_INIT;
      count_ex  <= COUNTER_INIT;
      history_q <= '0;
    end else begin
      if (advance) begin
        count_id <= count;
        count_ex <= count_id;
      end
      if (rollback_en_ex) begin
        history_q <= {history_shifted[HR_DEPTH-1:1], ~history_shifted[0]};
      end else if (corrected_en) begin
        history_q <= {history_q[HR_DEPTH-2:0], corrected_result};
      end
    end
  end

  index_hash u_hash_fetch (
    .pc    (pc),
    .hr    (history_q[HR_FETCH_LSB +: HR_WIDTH]),
    .index (index_fetch)
  );

  index_hash u_hash_id (
    .pc    (pc_id),
    .hr    (history_q[HR_ID_LSB +: HR_WIDTH]),
    .index (index_id)
  );

  index_hash u_hash_ex_rid (
    .pc    (pc_ex),
    .hr    (history_q[HR_EX_LSB +: HR_WIDTH]),
    .index (index_ex_rid)
  );

  index_hash u_hash_ex_nrid (
    .pc    (pc_ex),
    .hr    (history_q[HR_ID_LSB +: HR_WIDTH]),
    .index (index_ex_nrid)
  );

  assign index_conflict = (index_id == index_ex_rid); // Ex repair owns a shared entry.
  assign wr_en1         = rollback_en_id && !index_conflict;
  assign wr_en2         = rollback_en_ex || corrected_en;

  saturating_counter_step u_step_corrected (
    .count      (count),
    .decrement  (corrected_result),
    .next_count (step_corrected)
  );

  saturating_counter_step u_step_rollback (
    .count      (count_ex),
    .decrement  (!history_shifted[0]),
    .next_count (step_rollback)
  );

  assign wr_index2 = rollback_en_ex ? (rollback_en_id ? index_ex_rid : index_ex_nrid)
                                    : index_fetch;
  assign wr_count2 = rollback_en_ex ? step_rollback : step_corrected;

  pattern_history_table u_pht (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_index  (index_fetch),
    .wr_en1    (wr_en1),
    .wr_index1 (index_id),
    .wr_count1 (count_id),
    .wr_en2    (wr_en2),
    .wr_index2 (wr_index2),
    .wr_count2 (wr_count2),
    .rd_count  (count)
  );

endmodule

//--- logic/branch_predictor_top.sv
`timescale 1ns/1ps

module branch_predictor_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_ex,
  input  pipeline_pkg::pc_t       pc,
  input  logic                    corrected_en,
  input  logic                    corrected_result,
  input  logic                    rollback_en_id,
  input  logic                    rollback_en_ex,
  output predictor_pkg::counter_t count,
  output predictor_pkg::counter_t count_id,
  output predictor_pkg::counter_t count_ex
);

  import pipeline_pkg::*;

  pc_t pc_id;
  pc_t pc_ex;

  pc_stage_pipe u_pc_pipe (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall_ex (stall_ex),
    .pc       (pc),
    .pc_id    (pc_id),
    .pc_ex    (pc_ex)
  );

  // Staged pcs let the predictor rebuild the indices used in earlier stages.
  history_predictor u_predictor (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_ex         (stall_ex),
    .corrected_en     (corrected_en),
    .corrected_result (corrected_result),
    .rollback_en_id   (rollback_en_id),
    .rollback_en_ex   (rollback_en_ex),
    .pc               (pc),
    .pc_id            (pc_id),
    .pc_ex            (pc_ex),
    .count            (count),
    .count_id         (count_id),
    .count_ex         (count_ex)
  );

endmodule

//--- bench/bp_checker.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module bp_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_ex,
  input  pipeline_pkg::pc_t       pc,
  input  logic                    corrected_en,
  input  logic                    corrected_result,
  input  logic                    rollback_en_id,
  input  logic                    rollback_en_ex,
  input  predictor_pkg::counter_t count,
  input  predictor_pkg::counter_t count_id,
  input  predictor_pkg::counter_t count_ex,
  input  int                      test_id,
  input  logic                    done,
  output logic                    ready,
  output logic                    report_done,
  output int                      tests_passed,
  output int                      tests_failed
);

  import pipeline_pkg::*;
  import predictor_pkg::*;

  localparam int ENTRIES = 1 << `BP_INDEX_WIDTH;
  localparam int CNT_MAX = (1 << (`BP_COUNTER_WIDTH - 1)) - 1;
  localparam int CNT_MIN = -(1 << (`BP_COUNTER_WIDTH - 1));

  int       pht_m [ENTRIES];
  history_t hist_m;
  int       cnt_id_m;
  int       cnt_ex_m;
  pc_t      pc_id_m;
  pc_t      pc_ex_m;
  int       cur_test;
  int       cur_errors;

  // Pc word bits sit above a six bit history slice starting at lsb.
  function automatic int table_index(input pc_t pc_v, input history_t hist_v, input int lsb);
    int pc_part;
    int hr_part;
    pc_part = (pc_v >> 2) & ((1 << (`BP_INDEX_WIDTH - `BP_HR_WIDTH)) - 1);
    hr_part = (hist_v >> lsb) & ((1 << `BP_HR_WIDTH) - 1);
    return (pc_part << `BP_HR_WIDTH) | hr_part;
  endfunction

  function automatic int step_count(input int value, input logic down);
    if (down) begin
      return (value > CNT_MIN) ? value - 1 : value;
    end
    return (value < CNT_MAX) ? value + 1 : value;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
               $time, name, expected, actual);
      cur_errors++;
    end
  endtask

  task automatic finish_test();
    if (cur_test != 0) begin
      if (cur_errors == 0) begin
        $display("Test %0d passed", cur_test);
        tests_passed++;
      end else begin
        $display("Test %0d failed with %0d mismatches", cur_test, cur_errors);
        tests_failed++;
      end
    end
    cur_errors = 0;
  endtask

  // Model state moves on the same edge as the DUT, from inputs that settled 1 ns after the last edge.
  always @(posedge clk) begin
    int       fetch_idx;
    int       id_idx;
    int       ex_idx_rid;
    int       ex_idx;
    int       fetch_cnt;
    history_t shifted;
    if (!rst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        pht_m[i] = `BP_COUNTER_INIT;
      end
      hist_m   = '0;
      cnt_id_m = `BP_COUNTER_INIT;
      cnt_ex_m = `BP_COUNTER_INIT;
      pc_id_m  = '0;
      pc_ex_m  = '0;
    end else begin
      fetch_idx  = table_index(pc, hist_m, 0);
      id_idx     = table_index(pc_id_m, hist_m, 1);
      ex_idx_rid = table_index(pc_ex_m, hist_m, 2);
      ex_idx     = rollback_en_id ? ex_idx_rid : table_index(pc_ex_m, hist_m, 1);
      fetch_cnt  = pht_m[fetch_idx];
      shifted    = rollback_en_id ? (hist_m >> 1) : hist_m;

      if (rollback_en_id && id_idx != ex_idx_rid) begin
        pht_m[id_idx] = cnt_id_m;
      end
      if (rollback_en_ex) begin
        pht_m[ex_idx] = step_count(cnt_ex_m, !shifted[0]); // Applied last so it wins.
        hist_m        = shifted ^ history_t'(1);
      end else if (corrected_en) begin
        pht_m[fetch_idx] = step_count(fetch_cnt, corrected_result);
        hist_m           = (hist_m << 1) | history_t'(corrected_result);
      end

      if (!stall_ex) begin
        cnt_ex_m = cnt_id_m;
        cnt_id_m = fetch_cnt;
        pc_ex_m  = pc_id_m;
        pc_id_m  = pc;
      end
    end
  end

  always @(negedge clk) begin
    int exp_count;
    if (!rst_n) begin
      ready        = 1'b0;
      report_done  = 1'b0;
      tests_passed = 0;
      tests_failed = 0;
      cur_test     = 0;
      cur_errors   = 0;
    end else begin
      ready = 1'b1;
      if (test_id != cur_test && !report_done) begin
        finish_test();
        cur_test = test_id;
      end
      if (test_id != 0 && !report_done) begin
        exp_count = pht_m[table_index(pc, hist_m, 0)];
        check_value("count", exp_count, int'(count));
        check_value("count_id", cnt_id_m, int'(count_id));
        check_value("count_ex", cnt_ex_m, int'(count_ex));
      end
      if (done && !report_done) begin
        finish_test();
        report_done = 1'b1;
      end
    end
  end

endmodule

//--- bench/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

  import pipeline_pkg::*;
  import predictor_pkg::*;

  localparam int WAIT_LIMIT = 20;

  typedef struct {
    int          id;
    logic [31:0] pc;
    bit          rand_pc;
    logic        stall;
    logic        cen;
    logic        cres;
    logic        rid;
    logic        rex;
    int          reps;
  } row_t;

  logic     clk;
  logic     rst_n;
  logic     stall_ex;
  pc_t      pc;
  logic     corrected_en;
  logic     corrected_result;
  logic     rollback_en_id;
  logic     rollback_en_ex;
  counter_t count;
  counter_t count_id;
  counter_t count_ex;
  int       test_id;
  logic     done;
  logic     ready;
  logic     report_done;
  int       tests_passed;
  int       tests_failed;
  int       seed;
  row_t     rows[$];

  always #2 clk = ~clk;

  branch_predictor_top dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_ex         (stall_ex),
    .pc               (pc),
    .corrected_en     (corrected_en),
    .corrected_result (corrected_result),
    .rollback_en_id   (rollback_en_id),
    .rollback_en_ex   (rollback_en_ex),
    .count            (count),
    .count_id         (count_id),
    .count_ex         (count_ex)
  );

  bp_checker u_checker (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_ex         (stall_ex),
    .pc               (pc),
    .corrected_en     (corrected_en),
    .corrected_result (corrected_result),
    .rollback_en_id   (rollback_en_id),
    .rollback_en_ex   (rollback_en_ex),
    .count            (count),
    .count_id         (count_id),
    .count_ex         (count_ex),
    .test_id          (test_id),
    .done             (done),
    .ready            (ready),
    .report_done      (report_done),
    .tests_passed     (tests_passed),
    .tests_failed     (tests_failed)
  );

  task automatic add_row(input int id, input logic [31:0] row_pc, input bit rnd,
                         input logic stall, input logic cen, input logic cres,
                         input logic rid, input logic rex, input int reps);
    row_t r;
    r = '{id, row_pc, rnd, stall, cen, cres, rid, rex, reps};
    rows.push_back(r);
  endtask

  task automatic drive_row(input row_t r);
    test_id          = r.id;
    pc               = r.rand_pc ? $random(seed) : r.pc;
    stall_ex         = r.stall;
    corrected_en     = r.cen;
    corrected_result = r.cres;
    rollback_en_id   = r.rid;
    rollback_en_ex   = r.rex;
  endtask

  initial begin
    int waited;
    bit timed_out;
    timed_out        = 1'b0;
    seed             = 32'h6a81;
    clk              = 1'b0;
    rst_n            = 1'b0;
    stall_ex         = 1'b0;
    pc               = '0;
    corrected_en     = 1'b0;
    corrected_result = 1'b0;
    rollback_en_id   = 1'b0;
    rollback_en_ex   = 1'b0;
    test_id          = 0;
    done             = 1'b0;

    // id, pc, random pc, stall, corrected_en, result, rollback id, rollback ex, repeats
    add_row(1, 32'h0,   1, 0, 0, 0, 0, 0, 6);  // Fresh table reads zero everywhere.
    add_row(2, 32'h100, 0, 0, 1, 0, 0, 0, 4);  // Zeros keep the history fixed while walking up.
    add_row(2, 32'h100, 0, 0, 0, 0, 0, 0, 2);
    add_row(2, 32'h100, 0, 0, 1, 1, 0, 0, 10); // Settles on an all ones history, then walks down.
    add_row(3, 32'h100, 0, 0, 1, 0, 0, 0, 8);
    add_row(3, 32'h100, 0, 0, 1, 1, 0, 0, 1);  // One outcome moves the fetch index.
    add_row(3, 32'h100, 0, 0, 0, 0, 0, 0, 3);
    add_row(4, 32'h100, 0, 0, 0, 0, 0, 0, 2);  // Stages fill with the trained entry first.
    add_row(4, 32'h104, 0, 1, 0, 0, 0, 0, 4);
    add_row(4, 32'h0,   1, 1, 1, 0, 0, 0, 2);  // Training continues under stall.
    add_row(4, 32'h0,   1, 0, 0, 0, 0, 0, 3);
    add_row(5, 32'h0,   1, 0, 0, 0, 1, 0, 3);
    add_row(5, 32'h100, 0, 0, 1, 0, 0, 0, 8);
    add_row(5, 32'h104, 0, 0, 1, 0, 0, 0, 1);  // Moves the entry that id then restores.
    add_row(5, 32'h100, 0, 0, 0, 0, 1, 0, 1);
    add_row(5, 32'h104, 0, 0, 0, 0, 0, 0, 1);
    add_row(5, 32'h104, 0, 0, 1, 0, 0, 0, 1);
    add_row(5, 32'h104, 0, 0, 0, 0, 1, 0, 1);  // Same pc and clear history give equal indices.
    add_row(5, 32'h104, 0, 0, 0, 0, 0, 0, 2);
    add_row(6, 32'h108, 0, 0, 0, 0, 0, 1, 1);
    add_row(6, 32'h108, 0, 0, 1, 0, 0, 0, 6);  // Zeros move the repaired bit out of the fetch slice.
    add_row(6, 32'h104, 0, 0, 0, 0, 0, 0, 1);
    add_row(6, 32'h0,   1, 0, 0, 0, 1, 1, 3);
    add_row(6, 32'h10c, 0, 0, 1, 1, 0, 1, 2);  // Ex repair overrides the fetch update.
    add_row(7, 32'h0,   1, 0, 1, 0, 0, 0, 6);

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    waited = 0;
    while (ready !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (ready !== 1'b1) begin
      $display("Timeout: the checker never saw reset released.");
      timed_out = 1'b1;
    end

    if (!timed_out) begin
      foreach (rows[i]) begin
        for (int n = 0; n < rows[i].reps; n++) begin
          @(posedge clk);
          #1;
          drive_row(rows[i]);
        end
      end
      @(posedge clk);
      #1;
      corrected_en   = 1'b0;
      rollback_en_id = 1'b0;
      rollback_en_ex = 1'b0;
      stall_ex       = 1'b0;
      done           = 1'b1;

      waited = 0;
      while (report_done !== 1'b1 && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
      end
      if (report_done !== 1'b1) begin
        $display("Timeout: the checker did not finish its report.");
        timed_out = 1'b1;
      end
    end

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (timed_out || tests_failed != 0) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
logic/pipeline_pkg.sv
logic/predictor_pkg.sv
logic/index_hash.sv
logic/saturating_counter_step.sv
logic/pattern_history_table.sv
logic/pc_stage_pipe.sv
logic/history_predictor.sv
logic/branch_predictor_top.sv
bench/bp_checker.sv
bench/tb_branch_predictor.sv

//--- run_sim.sh
#!/bin/sh
# Builds the branch predictor testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -f vlog.f --top-module tb_branch_predictor \
  -Mdir "$BUILD_DIR" -o tb_branch_predictor
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/tb_branch_predictor" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi

exit 0
